// ==== logic/soc_pkg.sv ====
`default_nettype none

package soc_pkg;

  // --------------------------------------------------
  // Bus words
  // --------------------------------------------------
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [7:0]  uart_byte_t;

  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } htrans_t;

  typedef enum logic [2:0] {
    BYTE = 3'b000,
    HALF = 3'b001,
    WORD = 3'b010
  } hsize_t;

  // Address phase, master to slave
  typedef struct packed {
    addr_t   haddr;
    htrans_t htrans;
    hsize_t  hsize;
    logic    hwrite;
  } ahb_req_t;

  // Data phase response, slave to master
  typedef struct packed {
    data_t hrdata;
    logic  hreadyout;
    logic  hresp;
  } ahb_rsp_t;

  typedef enum logic [1:0] {
    SEL_NONE,
    SEL_RAM,
    SEL_UART
  } slave_sel_t;

  // --------------------------------------------------
  // Memory map, regions picked by haddr[31:28]
  // --------------------------------------------------
  localparam addr_t      RAM_BASE      = 32'h2000_0000;
  localparam addr_t      UART_BASE     = 32'h4000_0000;
  localparam int         RAM_ADDR_W    = 10;
  localparam logic [3:0] UART_DATA_OFS = 4'h0;
  localparam logic [3:0] UART_STAT_OFS = 4'h4;

  // Serial timing, simulation rate
  localparam int UART_BAUD_DIV   = 16;
  localparam int BAUD_CNT_W      = $clog2(UART_BAUD_DIV);
  // Start, eight data bits, stop
  localparam int UART_FRAME_BITS = 10;

endpackage

`default_nettype wire

// ==== logic/ahb_decoder.sv ====
`default_nettype none

module ahb_decoder (
  input  wire               clk,
  input  wire               RSTn,
  input  wire soc_pkg::ahb_req_t ahb_req,
  input  wire               hsel,
  input  wire               hready_in,
  output logic              ram_hsel,
  output logic              uart_hsel,
  input  wire soc_pkg::ahb_rsp_t ram_rsp,
  input  wire soc_pkg::ahb_rsp_t uart_rsp,
  output soc_pkg::ahb_rsp_t ahb_rsp
);
  import soc_pkg::*;

  slave_sel_t addr_sel;
  slave_sel_t data_sel;
  logic       live;

  // Region from the top nibble of the address phase
  always_comb begin
    addr_sel = SEL_NONE;
    if (hsel) begin
      if (ahb_req.haddr[31:28] == RAM_BASE[31:28]) begin
        addr_sel = SEL_RAM;
      end else if (ahb_req.haddr[31:28] == UART_BASE[31:28]) begin
        addr_sel = SEL_UART;
      end
    end
  end

  assign ram_hsel  = (addr_sel == SEL_RAM);
  assign uart_hsel = (addr_sel == SEL_UART);
  assign live      = (ahb_req.htrans == NONSEQ) || (ahb_req.htrans == SEQ);

  // Select carried into the data phase
  always_ff @(posedge clk or negedge RSTn) begin
    if (!RSTn) begin
      data_sel <= SEL_NONE;
    end else if (hready_in) begin
      data_sel <= live ? addr_sel : SEL_NONE;
    end
  end

  // Response mux, unmapped reads give zero
  always_comb begin
    case (data_sel)
      SEL_RAM:  ahb_rsp = ram_rsp;
      SEL_UART: ahb_rsp = uart_rsp;
      default:  ahb_rsp = '{hrdata: '0, hreadyout: 1'b1, hresp: 1'b0};
    endcase
  end

endmodule

`default_nettype wire

// ==== logic/ahb_bram.sv ====
`default_nettype none

module ahb_bram (
  input  wire               clk,
  input  wire               RSTn,
  input  wire soc_pkg::ahb_req_t ahb_req,
  input  wire               hsel,
  input  wire               hready,
  input  wire soc_pkg::data_t    hwdata,
  output soc_pkg::ahb_rsp_t ahb_rsp
);
  import soc_pkg::*;

  data_t                 mem [2**RAM_ADDR_W];
  logic                  live;
  logic [3:0]            lane_d;
  logic [3:0]            lane_q;
  logic [RAM_ADDR_W-1:0] addr_q;
  logic                  wr_q;

  assign live = hsel && hready &&
                ((ahb_req.htrans == NONSEQ) || (ahb_req.htrans == SEQ));

  // Byte lanes touched by this transfer
  always_comb begin
    case (ahb_req.hsize)
      BYTE:    lane_d = 4'b0001 << ahb_req.haddr[1:0];
      HALF:    lane_d = ahb_req.haddr[1] ? 4'b1100 : 4'b0011;
      default: lane_d = 4'b1111;
    endcase
  end

  // --------------------------------------------------
  // Address phase capture
  // --------------------------------------------------
  always_ff @(posedge clk or negedge RSTn) begin
    if (!RSTn) begin
      wr_q <= 1'b0;
    end else if (hready) begin
      wr_q <= live && ahb_req.hwrite;
    end
  end

  always_ff @(posedge clk) begin
    if (live) begin
      addr_q <= ahb_req.haddr[RAM_ADDR_W+1:2];
      lane_q <= lane_d;
    end
  end

  // --------------------------------------------------
  // Data phase
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (wr_q && hready) begin
      for (int i = 0; i < 4; i++) begin
        if (lane_q[i]) begin
          mem[addr_q][8*i +: 8] <= hwdata[8*i +: 8];
        end
      end
    end
  end

  // Read is asynchronous on the registered address
  assign ahb_rsp = '{hrdata: mem[addr_q], hreadyout: 1'b1, hresp: 1'b0};

endmodule

`default_nettype wire

// ==== logic/uart_baud_gen.sv ====
`default_nettype none

module uart_baud_gen (
  input  wire  clk,
  input  wire  RSTn,
  input  wire  bps_en,
  output logic bit_tick
);
  import soc_pkg::*;

  logic [BAUD_CNT_W-1:0] cnt;

  // Free count over one bit period, held at zero when idle
  always_ff @(posedge clk or negedge RSTn) begin
    if (!RSTn) begin
      cnt <= '0;
    end else if (!bps_en) begin
      cnt <= '0;
    end else if (cnt == BAUD_CNT_W'(UART_BAUD_DIV - 1)) begin
      cnt <= '0;
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  // Tick at the middle of the period
  assign bit_tick = bps_en && (cnt == BAUD_CNT_W'(UART_BAUD_DIV / 2 - 1));

endmodule

`default_nettype wire

// ==== logic/uart_rx.sv ====
`default_nettype none

module uart_rx (
  input  wire                  clk,
  input  wire                  RSTn,
  input  wire                  rxd,
  input  wire                  bit_tick,
  output logic                 bps_en,
  output logic                 rx_valid,
  output soc_pkg::uart_byte_t  rx_data
);
  import soc_pkg::*;

  logic                       rxd_q1;
  logic                       rxd_q2;
  logic                       rxd_q3;
  logic                       busy;
  logic [3:0]                 bit_cnt;
  logic [UART_FRAME_BITS-1:0] shift_q;
  logic                       start_edge;
  logic                       last_bit;

  // Synchronizer, third stage only for the edge
  always_ff @(posedge clk or negedge RSTn) begin
    if (!RSTn) begin
      rxd_q1 <= 1'b1;
      rxd_q2 <= 1'b1;
      rxd_q3 <= 1'b1;
    end else begin
      rxd_q1 <= rxd;
      rxd_q2 <= rxd_q1;
      rxd_q3 <= rxd_q2;
    end
  end

  assign start_edge = !busy && rxd_q3 && !rxd_q2;
  assign last_bit   = bit_cnt == 4'(UART_FRAME_BITS - 1);

  always_ff @(posedge clk or negedge RSTn) begin
    if (!RSTn) begin
      busy     <= 1'b0;
      bit_cnt  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      if (start_edge) begin
        busy    <= 1'b1;
        bit_cnt <= '0;
      end else if (busy && bit_tick) begin
        if (last_bit) begin
          busy    <= 1'b0;
          bit_cnt <= '0;
          // start sample still one place up, stop sample arriving now
          rx_valid <= !shift_q[1] && rxd_q2;
        end else begin
          bit_cnt <= bit_cnt + 1'b1;
        end
      end
    end
  end

  // Samples enter at the top, LSB ends up low
  always_ff @(posedge clk) begin
    if (busy && bit_tick) begin
      shift_q <= {rxd_q2, shift_q[UART_FRAME_BITS-1:1]};
    end
  end

  assign rx_data = shift_q[UART_FRAME_BITS-2:1];
  assign bps_en  = busy;

endmodule

`default_nettype wire

// ==== logic/uart_tx.sv ====
`default_nettype none

module uart_tx (
  input  wire                      clk,
  input  wire                      RSTn,
  input  wire                      tx_start,
  input  wire soc_pkg::uart_byte_t tx_data,
  input  wire                      bit_tick,
  output logic                     bps_en,
  output logic                     tx_busy,
  output logic                     txd
);
  import soc_pkg::*;

  logic                       busy;
  logic [3:0]                 bit_cnt;
  logic [UART_FRAME_BITS-1:0] frame_q;
  logic                       txd_q;

  // Line changes on each tick, one extra tick closes the stop bit
  always_ff @(posedge clk or negedge RSTn) begin
    if (!RSTn) begin
      busy    <= 1'b0;
      bit_cnt <= '0;
      txd_q   <= 1'b1;
    end else if (tx_start && !busy) begin
      busy    <= 1'b1;
      bit_cnt <= '0;
    end else if (busy && bit_tick) begin
      if (bit_cnt == 4'(UART_FRAME_BITS)) begin
        busy    <= 1'b0;
        bit_cnt <= '0;
      end else begin
        txd_q   <= frame_q[0];
        bit_cnt <= bit_cnt + 1'b1;
      end
    end
  end

  // Frame shifter, backfilled with idle level
  always_ff @(posedge clk) begin
    if (tx_start && !busy) begin
      frame_q <= {1'b1, tx_data, 1'b0};
    end else if (busy && bit_tick) begin
      frame_q <= {1'b1, frame_q[UART_FRAME_BITS-1:1]};
    end
  end

  assign txd     = txd_q;
  assign tx_busy = busy;
  assign bps_en  = busy;

endmodule

`default_nettype wire

// ==== logic/ahb_uart.sv ====
`default_nettype none

module ahb_uart (
  input  wire               clk,
  input  wire               RSTn,
  input  wire soc_pkg::ahb_req_t ahb_req,
  input  wire               hsel,
  input  wire               hready,
  input  wire soc_pkg::data_t    hwdata,
  output soc_pkg::ahb_rsp_t ahb_rsp,
  input  wire               rxd,
  output logic              txd,
  output logic              rx_irq
);
  import soc_pkg::*;

  logic       live;
  logic       wr_q;
  logic [3:0] ofs_q;
  data_t      rdata;
  uart_byte_t rx_byte;
  uart_byte_t rx_data_q;
  logic       rx_valid;
  logic       tx_start;
  logic       tx_busy;
  logic       bps_en_rx;
  logic       bps_en_tx;
  logic       bit_tick;

  assign live = hsel && hready &&
                ((ahb_req.htrans == NONSEQ) || (ahb_req.htrans == SEQ));

  // --------------------------------------------------
  // Register slave
  // --------------------------------------------------
  always_ff @(posedge clk or negedge RSTn) begin
    if (!RSTn) begin
      wr_q <= 1'b0;
    end else if (hready) begin
      wr_q <= live && ahb_req.hwrite;
    end
  end

  always_ff @(posedge clk) begin
    if (live) begin
      ofs_q <= ahb_req.haddr[3:0];
    end
  end

  // Writes during a frame are dropped
  assign tx_start = wr_q && hready && (ofs_q == UART_DATA_OFS) && !tx_busy;

  always_ff @(posedge clk) begin
    if (rx_valid) begin
      rx_data_q <= rx_byte;
    end
  end

  always_comb begin
    case (ofs_q)
      UART_DATA_OFS: rdata = {24'd0, rx_data_q};
      UART_STAT_OFS: rdata = {31'd0, tx_busy};
      default:       rdata = '0;
    endcase
  end

  assign ahb_rsp = '{hrdata: rdata, hreadyout: 1'b1, hresp: 1'b0};
  assign rx_irq  = rx_valid;

  // --------------------------------------------------
  // Serial side
  // --------------------------------------------------
  uart_baud_gen u_baud (
    .clk      (clk),
    .RSTn     (RSTn),
    .bps_en   (bps_en_rx | bps_en_tx),
    .bit_tick (bit_tick)
  );

  uart_rx u_rx (
    .clk      (clk),
    .RSTn     (RSTn),
    .rxd      (rxd),
    .bit_tick (bit_tick),
    .bps_en   (bps_en_rx),
    .rx_valid (rx_valid),
    .rx_data  (rx_byte)
  );

  uart_tx u_tx (
    .clk      (clk),
    .RSTn     (RSTn),
    .tx_start (tx_start),
    .tx_data  (hwdata[7:0]),
    .bit_tick (bit_tick),
    .bps_en   (bps_en_tx),
    .tx_busy  (tx_busy),
    .txd      (txd)
  );

endmodule

`default_nettype wire

// ==== logic/uart_soc.sv ====
`default_nettype none

module uart_soc (
  input  wire                    clk,
  input  wire                    RSTn,
  input  wire soc_pkg::ahb_req_t ahb_req,
  input  wire                    hsel,
  input  wire soc_pkg::data_t    hwdata,
  input  wire                    hready_in,
  output soc_pkg::ahb_rsp_t      ahb_rsp,
  input  wire                    rxd,
  output logic                   txd,
  output logic                   rx_irq
);
  import soc_pkg::*;

  logic     ram_hsel;
  logic     uart_hsel;
  ahb_rsp_t ram_rsp;
  ahb_rsp_t uart_rsp;

  // --------------------------------------------------
  // Interconnect
  // --------------------------------------------------
  ahb_decoder u_decoder (
    .clk       (clk),
    .RSTn      (RSTn),
    .ahb_req   (ahb_req),
    .hsel      (hsel),
    .hready_in (hready_in),
    .ram_hsel  (ram_hsel),
    .uart_hsel (uart_hsel),
    .ram_rsp   (ram_rsp),
    .uart_rsp  (uart_rsp),
    .ahb_rsp   (ahb_rsp)
  );

  // Data RAM
  ahb_bram u_ram (
    .clk     (clk),
    .RSTn    (RSTn),
    .ahb_req (ahb_req),
    .hsel    (ram_hsel),
    .hready  (hready_in),
    .hwdata  (hwdata),
    .ahb_rsp (ram_rsp)
  );

  // Serial port
  ahb_uart u_uart (
    .clk     (clk),
    .RSTn    (RSTn),
    .ahb_req (ahb_req),
    .hsel    (uart_hsel),
    .hready  (hready_in),
    .hwdata  (hwdata),
    .ahb_rsp (uart_rsp),
    .rxd     (rxd),
    .txd     (txd),
    .rx_irq  (rx_irq)
  );

endmodule

`default_nettype wire

// ==== verification/uart_soc_tb.sv ====
`default_nettype none

module uart_soc_tb;
  import soc_pkg::*;

  logic       clk;
  logic       RSTn;
  ahb_req_t   ahb_req;
  logic       hsel;
  data_t      hwdata;
  logic       hready_in;
  ahb_rsp_t   ahb_rsp;
  logic       rxd;
  logic       txd;
  logic       rx_irq;

  logic [31:0] lcg_state;
  data_t       ram_model [2**RAM_ADDR_W];
  uart_byte_t  rx_expect;
  int          checks;
  int          word_errs;
  int          byte_errs;
  int          bit_errs;
  int          other_errs;

  uart_soc dut (
    .clk       (clk),
    .RSTn      (RSTn),
    .ahb_req   (ahb_req),
    .hsel      (hsel),
    .hwdata    (hwdata),
    .hready_in (hready_in),
    .ahb_rsp   (ahb_rsp),
    .rxd       (rxd),
    .txd       (txd),
    .rx_irq    (rx_irq)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Run limit of twice the test lengths plus slack
  initial begin
    int run_cycles;
    run_cycles = 4 + 2 * 32 * 2 + 8 * 2 + 6 * 2
               + (UART_FRAME_BITS + 2) * UART_BAUD_DIV + 32 * 2
               + 2 * ((UART_FRAME_BITS + 2) * UART_BAUD_DIV + 2);
    repeat (2 * run_cycles + 200) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the run did not finish",
             2 * run_cycles + 200);
    $display("Test FAILED");
    $finish;
  end

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // --------------------------------------------------
  // Compare tasks
  // --------------------------------------------------
  task automatic check_word(input string name, input data_t got, input data_t exp);
    checks++;
    if (got !== exp) begin
      word_errs++;
      $display("[ERROR] %0t %s: got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_byte(input string name, input uart_byte_t got, input uart_byte_t exp);
    checks++;
    if (got !== exp) begin
      byte_errs++;
      $display("[ERROR] %0t %s: got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      bit_errs++;
      $display("[ERROR] %0t %s: got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic flag_failure(input string msg);
    other_errs++;
    $display("%0t: %s", $time, msg);
  endtask

  // --------------------------------------------------
  // Bus master with address and data phases
  // --------------------------------------------------
  task automatic bus_idle();
    ahb_req = '{haddr: '0, htrans: IDLE, hsize: WORD, hwrite: 1'b0};
    hsel    = 1'b0;
  endtask

  task automatic ahb_write(input addr_t addr, input hsize_t size, input data_t data);
    @(negedge clk);
    ahb_req = '{haddr: addr, htrans: NONSEQ, hsize: size, hwrite: 1'b1};
    hsel    = 1'b1;
    @(negedge clk);
    bus_idle();
    hwdata = data;
  endtask

  task automatic ahb_read(input addr_t addr, input hsize_t size, output ahb_rsp_t rsp);
    @(negedge clk);
    ahb_req = '{haddr: addr, htrans: NONSEQ, hsize: size, hwrite: 1'b0};
    hsel    = 1'b1;
    @(negedge clk);
    rsp = ahb_rsp;
    bus_idle();
  endtask

  // One serial frame plus two idle bit times while counting irq pulses
  task automatic drive_rx_frame(input uart_byte_t value, input logic stop_bit,
                                output int pulses);
    logic [UART_FRAME_BITS-1:0] frame;
    pulses = 0;
    frame  = {stop_bit, value, 1'b0};
    for (int i = 0; i < UART_FRAME_BITS + 2; i++) begin
      for (int k = 0; k < UART_BAUD_DIV; k++) begin
        @(negedge clk);
        if (rx_irq === 1'b1) begin
          pulses++;
        end
        rxd = (i < UART_FRAME_BITS) ? frame[i] : 1'b1;
      end
    end
  endtask

  // --------------------------------------------------
  // Tests
  // --------------------------------------------------
  task automatic reset_state_test();
    ahb_rsp_t rsp;
    check_bit("txd", txd, 1'b1);
    check_bit("rx_irq", rx_irq, 1'b0);
    check_bit("hreadyout", ahb_rsp.hreadyout, 1'b1);
    check_bit("hresp", ahb_rsp.hresp, 1'b0);
    ahb_read(UART_BASE + addr_t'(UART_STAT_OFS), WORD, rsp);
    check_bit("tx_busy after reset", rsp.hrdata[0], 1'b0);
  endtask

  task automatic ram_word_test();
    int       idx_list [32];
    int       idx;
    data_t    d;
    ahb_rsp_t rsp;
    for (int i = 0; i < 32; i++) begin
      d   = next_rand();
      idx = int'(d[RAM_ADDR_W-1:0]);
      d   = next_rand();
      ahb_write(RAM_BASE + addr_t'(idx * 4), WORD, d);
      ram_model[idx] = d;
      idx_list[i]    = idx;
    end
    for (int i = 0; i < 32; i++) begin
      ahb_read(RAM_BASE + addr_t'(idx_list[i] * 4), WORD, rsp);
      check_word($sformatf("ram[%0d]", idx_list[i]), rsp.hrdata, ram_model[idx_list[i]]);
    end
  endtask

  task automatic byte_lane_test();
    logic [31:0] r;
    int          idx;
    int          bofs;
    int          hofs;
    uart_byte_t  bval;
    logic [15:0] hval;
    data_t       exp;
    ahb_rsp_t    rsp;
    r   = next_rand();
    idx = int'(r[RAM_ADDR_W-1:0]);
    exp = next_rand();
    ahb_write(RAM_BASE + addr_t'(idx * 4), WORD, exp);
    r    = next_rand();
    bofs = int'(r[1:0]);
    bval = r[15:8];
    hofs = r[16] ? 2 : 0;
    hval = r[31:16];
    // Sub-word data travels on its own lanes
    ahb_write(RAM_BASE + addr_t'(idx * 4 + bofs), BYTE, data_t'(bval) << (8 * bofs));
    exp[8*bofs +: 8] = bval;
    ahb_write(RAM_BASE + addr_t'(idx * 4 + hofs), HALF, data_t'(hval) << (8 * hofs));
    exp[8*hofs +: 16] = hval;
    ram_model[idx] = exp;
    ahb_read(RAM_BASE + addr_t'(idx * 4), WORD, rsp);
    check_word($sformatf("ram[%0d] lanes", idx), rsp.hrdata, exp);
  endtask

  task automatic unmapped_test();
    data_t    d;
    ahb_rsp_t rsp;
    d = next_rand();
    ahb_write(RAM_BASE, WORD, d);
    ram_model[0] = d;
    ahb_write(32'h8000_0000, WORD, ~d);
    ahb_read(32'h8000_0000, WORD, rsp);
    check_word("unmapped hrdata", rsp.hrdata, '0);
    check_bit("unmapped hresp", rsp.hresp, 1'b0);
    ahb_read(RAM_BASE, WORD, rsp);
    check_word("ram[0] after unmapped write", rsp.hrdata, d);
  endtask

  task automatic transmit_test();
    logic [31:0] r;
    uart_byte_t  b;
    ahb_rsp_t    rsp;
    int          n;
    logic        busy_seen;
    r = next_rand();
    b = r[7:0];
    ahb_write(UART_BASE + addr_t'(UART_DATA_OFS), WORD, {24'd0, b});
    ahb_read(UART_BASE + addr_t'(UART_STAT_OFS), WORD, rsp);
    check_bit("tx_busy after write", rsp.hrdata[0], 1'b1);
    n = 0;
    while (txd !== 1'b0 && n < 2 * UART_BAUD_DIV) begin
      @(negedge clk);
      n++;
    end
    if (txd !== 1'b0) begin
      flag_failure("Transmit: TXD never dropped for the start bit");
    end else begin
      // Move to the middle of the start bit
      repeat (UART_BAUD_DIV / 2) @(negedge clk);
      check_bit("txd start bit", txd, 1'b0);
      for (int i = 0; i < 8; i++) begin
        repeat (UART_BAUD_DIV) @(negedge clk);
        check_bit($sformatf("txd data bit %0d", i), txd, b[i]);
      end
      repeat (UART_BAUD_DIV) @(negedge clk);
      check_bit("txd stop bit", txd, 1'b1);
    end
    busy_seen = 1'b1;
    n = 0;
    while (busy_seen && n < 2 * UART_BAUD_DIV) begin
      ahb_read(UART_BASE + addr_t'(UART_STAT_OFS), WORD, rsp);
      busy_seen = rsp.hrdata[0];
      n++;
    end
    check_bit("tx_busy after frame", busy_seen, 1'b0);
  endtask

  task automatic receive_test();
    logic [31:0] r;
    int          pulses;
    ahb_rsp_t    rsp;
    r         = next_rand();
    rx_expect = r[23:16];
    drive_rx_frame(rx_expect, 1'b1, pulses);
    if (pulses == 0) begin
      flag_failure("Receive: timeout, no rx_irq pulse within two bit times after the stop bit");
    end else if (pulses > 1) begin
      flag_failure("Receive: rx_irq pulsed more than once for one frame");
    end
    ahb_read(UART_BASE + addr_t'(UART_DATA_OFS), WORD, rsp);
    check_byte("uart rx data", rsp.hrdata[7:0], rx_expect);
    check_bit("uart rx hresp", rsp.hresp, 1'b0);
  endtask

  task automatic framing_error_test();
    logic [31:0] r;
    int          pulses;
    ahb_rsp_t    rsp;
    r = next_rand();
    // Stop bit held low so the byte is dropped
    // The dropped byte never equals the held one
    drive_rx_frame(rx_expect ^ (r[7:0] | 8'h01), 1'b0, pulses);
    check_bit("rx_irq on bad frame", pulses != 0, 1'b0);
    ahb_read(UART_BASE + addr_t'(UART_DATA_OFS), WORD, rsp);
    check_byte("uart rx data after bad frame", rsp.hrdata[7:0], rx_expect);
  endtask

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------
  initial begin
    int total;
    RSTn       = 1'b0;
    hwdata     = '0;
    hready_in  = 1'b1;
    rxd        = 1'b1;
    lcg_state  = 32'hb56e_bcc1;
    checks     = 0;
    word_errs  = 0;
    byte_errs  = 0;
    bit_errs   = 0;
    other_errs = 0;
    bus_idle();
    repeat (2) @(posedge clk);
    @(negedge clk);
    RSTn = 1'b1;

    reset_state_test();
    ram_word_test();
    byte_lane_test();
    unmapped_test();
    transmit_test();
    receive_test();
    framing_error_test();
    repeat (4) @(negedge clk);

    total = word_errs + byte_errs + bit_errs + other_errs;
    $display("Checks %0d, errors: word %0d, byte %0d, bit %0d, other %0d",
             checks, word_errs, byte_errs, bit_errs, other_errs);
    if (total == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
logic/soc_pkg.sv
logic/ahb_decoder.sv
logic/ahb_bram.sv
logic/uart_baud_gen.sv
logic/uart_rx.sv
logic/uart_tx.sv
logic/ahb_uart.sv
logic/uart_soc.sv
verification/uart_soc_tb.sv

// ==== Makefile ====
# Verilator build and run for the AHB-Lite UART system

VERILATOR ?= verilator
TOP       ?= uart_soc_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only -Wall --timing

SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx 'Test OK' $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
